//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - biu_pkg.sv
  - icache_pkg.sv
  - icache_setup.sv
  - icache_tag.sv
  - icache_memory.sv
  - icache_hit.sv
  - icache_biu_ctrl.sv
  - icache_top.sv
  - target: test
    files:
      - icache_chk.sv
      - icache_tb.sv

//--- biu_pkg.sv
// Bus interface encodings
// Only the values used by the line fill are listed
package biu_pkg;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_e;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR4  = 3'b011   // Four-beat incrementing burst
  } biu_type_e;

endpackage

//--- icache_biu_ctrl.sv
// Line-fill controller toward the bus interface, one fill at a time
// Beats count from the cycle after biu_stb_ack_i
// An error on any beat ends the fill early with fill_err_o set
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_biu_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  icache_pkg::biucmd_e     biucmd_i,
  input  logic [`ICACHE_XLEN-1:0] fill_adr_i,
  input  logic                    biu_stb_ack_i,
  input  logic                    biu_ack_i,      // Beat valid
  input  logic                    biu_err_i,
  input  logic [`ICACHE_XLEN-1:0] biu_q_i,
  output logic                    biucmd_ack_o,
  output logic                    fill_err_o,
  output icache_pkg::line_t       biu_line_o,
  output logic                    biu_stb_o,
  output logic [`ICACHE_XLEN-1:0] biu_adri_o,
  output biu_pkg::biu_size_e      biu_size_o,
  output biu_pkg::biu_type_e      biu_type_o,
  output logic                    biu_we_o
);

  typedef enum logic [1:0] {
    BIU_IDLE,
    BIU_REQ,      // Strobe up, waiting for acceptance
    BIU_BURST,
    BIU_DONE      // Completion pulse
  } biu_state_e;

  biu_state_e                   state_q;
  logic [`ICACHE_BEAT_BITS-1:0] beat_q;
  logic                         err_q;
  icache_pkg::line_t            line_q;
  logic                         last_beat;

  assign last_beat = beat_q == `ICACHE_BEAT_BITS'(`ICACHE_BURST - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BIU_IDLE;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        BIU_IDLE: begin
          if (biucmd_i == icache_pkg::BIUCMD_READLINE) begin
            state_q <= BIU_REQ;
            beat_q  <= '0;
            err_q   <= 1'b0;
          end
        end
        BIU_REQ: if (biu_stb_ack_i) state_q <= BIU_BURST;
        BIU_BURST: begin
          if (biu_ack_i) beat_q <= beat_q + 1'b1;
          if (biu_err_i) begin
            err_q   <= 1'b1;
            state_q <= BIU_DONE;
          end else if (biu_ack_i && last_beat) begin
            state_q <= BIU_DONE;
          end
        end
        default: state_q <= BIU_IDLE;   // Hit stage has left FILL by now
      endcase
    end
  end

  // Beat k lands in word k of the line
  always_ff @(posedge clk_i) begin
    if (state_q == BIU_BURST && biu_ack_i) begin
      line_q[beat_q*`ICACHE_XLEN +: `ICACHE_XLEN] <= biu_q_i;
    end
  end

  assign biucmd_ack_o = state_q == BIU_DONE;
  assign fill_err_o   = err_q;
  assign biu_line_o   = line_q;
  assign biu_stb_o    = state_q == BIU_REQ;
  assign biu_adri_o   = fill_adr_i;         // Held stable by the tag stage
  assign biu_size_o   = biu_pkg::WORD;
  assign biu_type_o   = biu_pkg::INCR4;
  assign biu_we_o     = 1'b0;               // Read only

endmodule

//--- icache_chk.sv
// Bound into icache_top, expects the bus model data pattern pc ^ 32'hA5A5_0000
// fail_cnt holds the number of failed assertions so far
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_chk (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    mem_req_i,
  input logic                    mem_ack_o,
  input logic                    parcel_valid_o,
  input logic [`ICACHE_XLEN-1:0] parcel_o,
  input logic [`ICACHE_XLEN-1:0] parcel_pc_o,
  input logic                    parcel_error_o,
  input logic                    biu_stb_o,
  input biu_pkg::biu_size_e      biu_size_o,
  input logic                    biu_we_o
);

  localparam logic [`ICACHE_XLEN-1:0] DataXor = 32'hA5A5_0000;   // Bus model pattern

  int   fail_cnt = 0;
  logic seen_req;   // Core has asked at least once

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_req <= 1'b0;
    end else if (mem_req_i) begin
      seen_req <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // Reset and idle behavior
  // ---------------------------------------------------------------------------
  a_reset_quiet: assert property (@(posedge clk_i)
    !seen_req |-> !biu_stb_o && !parcel_valid_o && !parcel_error_o && mem_ack_o)
    else begin
      $error("outputs active or core stalled before the first request");
      fail_cnt++;
    end

  // ---------------------------------------------------------------------------
  // Data and stall
  // ---------------------------------------------------------------------------
  a_parcel_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    parcel_valid_o && !parcel_error_o |-> parcel_o == (parcel_pc_o ^ DataXor))
    else begin
      $error("ERR parcel_data at pc %h: expected %h, actual %h", $sampled(parcel_pc_o),
             $sampled(parcel_pc_o) ^ DataXor, $sampled(parcel_o));
      fail_cnt++;
    end

  a_stall_on_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o |-> !mem_ack_o)   // Core held off while a burst is requested
    else begin
      $error("mem_ack_o high while biu_stb_o is raised");
      fail_cnt++;
    end

  // ---------------------------------------------------------------------------
  // Bus request attributes
  // ---------------------------------------------------------------------------
  a_bus_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o |-> biu_size_o == biu_pkg::WORD)   // Word beats only
    else begin
      $error("ERR bus_size: expected %0d, actual %0d", biu_pkg::WORD,
             $sampled(biu_size_o));
      fail_cnt++;
    end

  a_bus_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !biu_we_o)
    else begin
      $error("ERR bus_we: expected 0, actual %b", $sampled(biu_we_o));
      fail_cnt++;
    end

endmodule

//--- icache_hit.sv
// Hit stage with the fill FSM and the parcel output
// A miss stalls the front stages until the fill completes
// RECOVER is an unstalled bubble, the memory re-reads the held setup index
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_hit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    tag_req_i,
  input  logic [`ICACHE_XLEN-1:0] tag_adr_i,
  input  logic                    hit_i,
  input  icache_pkg::line_t       cache_line_i,
  input  logic                    biucmd_ack_i,   // Fill done pulse
  input  logic                    fill_err_i,
  input  icache_pkg::line_t       biu_line_i,
  output logic                    stall_o,
  output logic                    filling_o,
  output logic                    fill_we_o,
  output icache_pkg::biucmd_e     biucmd_o,
  output logic [`ICACHE_XLEN-1:0] fill_adr_o,     // Line aligned
  output icache_pkg::idx_t        wr_idx_o,
  output icache_pkg::tag_t        wr_tag_o,
  output logic                    parcel_valid_o,
  output logic [`ICACHE_XLEN-1:0] parcel_o,
  output logic [`ICACHE_XLEN-1:0] parcel_pc_o,
  output logic                    parcel_error_o
);

  icache_pkg::fill_state_e      state_q;
  icache_pkg::fill_state_e      state_d;
  logic                         miss;
  logic [`ICACHE_BEAT_BITS-1:0] word_sel;

  function automatic logic [`ICACHE_XLEN-1:0] pick_word(
    input icache_pkg::line_t            line,
    input logic [`ICACHE_BEAT_BITS-1:0] sel
  );
    return line[sel*`ICACHE_XLEN +: `ICACHE_XLEN];
  endfunction

  assign word_sel = tag_adr_i[`ICACHE_OFFS_BITS-1 -: `ICACHE_BEAT_BITS];   // Bits 3:2
  assign miss     = tag_req_i & ~hit_i;

  // -------------------------------------------------------------------------
  // Fill FSM
  // -------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::ARMED:   if (miss) state_d = icache_pkg::FILL;
      icache_pkg::FILL:    if (biucmd_ack_i) state_d = icache_pkg::RECOVER;
      default:             state_d = icache_pkg::ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= icache_pkg::ARMED;
    end else begin
      state_q <= state_d;
    end
  end

  // Stall rises in the miss cycle itself
  assign stall_o   = (state_q == icache_pkg::ARMED && miss) || state_q == icache_pkg::FILL;
  assign filling_o = state_q == icache_pkg::FILL;
  assign biucmd_o  = filling_o ? icache_pkg::BIUCMD_READLINE : icache_pkg::BIUCMD_NOP;
  assign fill_we_o = filling_o & biucmd_ack_i & ~fill_err_i;   // Failed lines not stored

  // Missed request is held in the tag stage for the whole fill
  assign fill_adr_o = {tag_adr_i[`ICACHE_XLEN-1:`ICACHE_OFFS_BITS], {`ICACHE_OFFS_BITS{1'b0}}};
  assign wr_idx_o   = tag_adr_i[`ICACHE_OFFS_BITS +: `ICACHE_IDX_BITS];
  assign wr_tag_o   = tag_adr_i[`ICACHE_XLEN-1 -: `ICACHE_TAG_BITS];

  // -------------------------------------------------------------------------
  // Parcel output
  // -------------------------------------------------------------------------
  assign parcel_pc_o = tag_adr_i;

  always_comb begin
    parcel_valid_o = 1'b0;
    parcel_error_o = 1'b0;
    parcel_o       = pick_word(cache_line_i, word_sel);
    case (state_q)
      icache_pkg::ARMED: parcel_valid_o = tag_req_i & hit_i;
      icache_pkg::FILL: begin
        if (biucmd_ack_i) begin   // Missed word straight from the fill buffer
          parcel_valid_o = 1'b1;
          parcel_error_o = fill_err_i;
          parcel_o       = pick_word(biu_line_i, word_sel);
        end
      end
      default: parcel_valid_o = 1'b0;   // RECOVER drops the served miss
    endcase
  end

endmodule

//--- icache_macros.svh
// Fixed geometry of the instruction cache: 2 ways x 16 sets x 16-byte lines
// The line packing and the burst counter only work for these exact values
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

`define ICACHE_XLEN        32   // Word and address width
`define ICACHE_LINE_BYTES  16   // Bytes per cache line
`define ICACHE_BURST       4    // Beats per line fill
`define ICACHE_WAYS        2
`define ICACHE_SETS        16

// Address split is tag | index | offset
`define ICACHE_OFFS_BITS   4
`define ICACHE_IDX_BITS    4
`define ICACHE_TAG_BITS    24
`define ICACHE_BEAT_BITS   2    // Word-in-line select

`endif

//--- icache_memory.sv
// Tag, valid and data arrays for both ways
// Read data appears one cycle after rd_idx_i, writes are seen one read later
// Victim way comes from a 7-bit LFSR frozen during a fill
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_memory (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  icache_pkg::idx_t  rd_idx_i,
  input  icache_pkg::tag_t  core_tag_i,   // Tag stage tag
  input  icache_pkg::idx_t  wr_idx_i,
  input  icache_pkg::tag_t  wr_tag_i,
  input  logic              fill_we_i,
  input  logic              filling_i,
  input  icache_pkg::line_t biu_line_i,
  output logic              hit_o,
  output icache_pkg::line_t cache_line_o
);

  logic [6:0]              lfsr_q;
  logic                    fill_way;      // Two ways, one bit
  logic [`ICACHE_WAYS-1:0] valid_q [`ICACHE_SETS];
  icache_pkg::tag_t        tag_mem [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::line_t       dat_mem [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] rd_valid_q;
  icache_pkg::tag_t        rd_tag_q  [`ICACHE_WAYS];
  icache_pkg::line_t       rd_line_q [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] way_hit;

  // -------------------------------------------------------------------------
  // Way replacement
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!filling_i) begin
      lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};   // XNOR taps, all-zero safe
    end
  end

  assign fill_way = lfsr_q[0];

  // -------------------------------------------------------------------------
  // Arrays
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
      rd_valid_q <= '0;
    end else begin
      if (fill_we_i) begin
        valid_q[wr_idx_i][fill_way] <= 1'b1;
      end
      rd_valid_q <= valid_q[rd_idx_i];   // Old value on a same-edge write
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_we_i) begin
      tag_mem[wr_idx_i][fill_way] <= wr_tag_i;
      dat_mem[wr_idx_i][fill_way] <= biu_line_i;
    end
    for (int w = 0; w < `ICACHE_WAYS; w++) begin   // Read every cycle
      rd_tag_q[w]  <= tag_mem[rd_idx_i][w];
      rd_line_q[w] <= dat_mem[rd_idx_i][w];
    end
  end

  // Way compare, at most one way holds a given tag
  always_comb begin
    cache_line_o = rd_line_q[0];
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_hit[w] = rd_valid_q[w] & (rd_tag_q[w] == core_tag_i);
      if (way_hit[w]) begin
        cache_line_o = rd_line_q[w];
      end
    end
  end

  assign hit_o = |way_hit;

endmodule

//--- icache_pkg.sv
// Cache-side types built on the geometry macros
// Lines pack word 0 into the low bits
`include "icache_macros.svh"

package icache_pkg;

  // Hit stage FSM
  typedef enum logic [1:0] {
    ARMED,      // Looking up requests
    FILL,       // Waiting on the line fill
    RECOVER     // One bubble after the fill
  } fill_state_e;

  // Hit stage to bus controller
  typedef enum logic {
    BIUCMD_NOP,
    BIUCMD_READLINE
  } biucmd_e;

  typedef logic [`ICACHE_TAG_BITS-1:0]     tag_t;
  typedef logic [`ICACHE_IDX_BITS-1:0]     idx_t;
  typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;

endpackage

//--- icache_setup.sv
// Address setup stage of the fetch pipeline
// A request is taken on every edge where stall_i is low
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_setup (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    stall_i,      // Freeze stage
  input  logic                    req_i,
  input  logic [`ICACHE_XLEN-1:0] adr_i,        // Word aligned
  output logic                    setup_req_o,
  output logic [`ICACHE_XLEN-1:0] setup_adr_o,
  output icache_pkg::idx_t        rd_idx_o      // Memory read index
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_req_o <= 1'b0;
    end else if (!stall_i) begin
      setup_req_o <= req_i;
    end
  end

  // Address only matters while setup_req_o is set
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      setup_adr_o <= adr_i;
    end
  end

  // Held index keeps the memory re-reading the same set under stall
  assign rd_idx_o = setup_adr_o[`ICACHE_OFFS_BITS +: `ICACHE_IDX_BITS];

endmodule

//--- icache_tag.sv
// Tag stage, second pipeline register
// Lines up with the synchronous memory output on every unstalled edge
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_tag (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    stall_i,
  input  logic                    req_i,        // From setup stage
  input  logic [`ICACHE_XLEN-1:0] adr_i,
  output logic                    tag_req_o,
  output logic [`ICACHE_XLEN-1:0] tag_adr_o
);

  // Under stall the missed request stays here for the fill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_req_o <= 1'b0;
    end else if (!stall_i) begin
      tag_req_o <= req_i;   // Empty or delivered, take the next one
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      tag_adr_o <= adr_i;
    end
  end

endmodule

//--- icache_tb.sv
// Testbench for icache_top with a four-beat burst bus model
// Bus data is address ^ 32'hA5A5_0000, bit 31 addresses fail on the last beat
// Checking is done by the bound icache_chk assertions plus per-test counts
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_tb;

  localparam int NumRand    = 200;   // Random fetches in the last test
  localparam int MissCycles = 12;    // Worst case fill incl. strobe delay
  localparam int MaxCycles  = (NumRand + 40) * MissCycles + 120;   // Every fetch a miss

  logic                    clk_i;
  logic                    rst_ni;
  logic                    mem_req_i;
  logic [`ICACHE_XLEN-1:0] mem_adr_i;
  logic                    mem_ack_o;
  logic                    parcel_valid_o;
  logic [`ICACHE_XLEN-1:0] parcel_o;
  logic [`ICACHE_XLEN-1:0] parcel_pc_o;
  logic                    parcel_error_o;
  logic                    biu_stb_o;
  logic                    biu_stb_ack_i;
  logic [`ICACHE_XLEN-1:0] biu_adri_o;
  biu_pkg::biu_size_e      biu_size_o;
  biu_pkg::biu_type_e      biu_type_o;
  logic                    biu_we_o;
  logic [`ICACHE_XLEN-1:0] biu_q_i;
  logic                    biu_ack_i;
  logic                    biu_err_i;

  integer seed;
  integer bus_seed;                  // Own stream for the bus model
  logic [`ICACHE_XLEN-1:0] bus_adr;
  logic                    stb_q;
  biu_pkg::biu_type_e      stb_type;   // Type seen on the last strobe
  int cycles = 0;
  int accepted = 0;
  int parcels = 0;
  int perrs = 0;
  int stb_cnt = 0;
  int errors = 0;
  int ntests = 0;
  int nfailed = 0;
  int acc_base, par_base, perr_base, stb_base, chk_base;

  bind icache_top icache_chk i_chk (.*);

  icache_top i_dut (.*);

  always #50 clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // Bus model, strobe ack after 0..3 cycles then four beats
  // ---------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && biu_stb_o) begin
      bus_adr = biu_adri_o;
      repeat ({$random(bus_seed)} % 4) @(negedge clk_i);
      biu_stb_ack_i = 1'b1;
      @(negedge clk_i);
      biu_stb_ack_i = 1'b0;
      for (int k = 0; k < `ICACHE_BURST; k++) begin
        biu_ack_i = 1'b1;
        biu_q_i   = (bus_adr + 4 * k) ^ 32'hA5A5_0000;
        biu_err_i = bus_adr[31] && k == `ICACHE_BURST - 1;   // Last beat only
        @(negedge clk_i);
      end
      biu_ack_i = 1'b0;
      biu_err_i = 1'b0;
    end
  end

  // Counts sampled mid-cycle, outputs are stable there
  always @(negedge clk_i) begin
    cycles++;
    if (rst_ni && parcel_valid_o) parcels++;
    if (rst_ni && parcel_valid_o && parcel_error_o) perrs++;
    if (biu_stb_o && !stb_q) begin   // Rising edge of the strobe
      stb_cnt++;
      stb_type = biu_type_o;
    end
    stb_q = biu_stb_o;
  end

  initial begin : watchdog
    wait (cycles >= MaxCycles);
    $display("Run stopped after %0d cycles, the DUT did not finish the tests", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  // Called at a falling edge, returns one falling edge after acceptance
  task automatic fetch(input logic [`ICACHE_XLEN-1:0] adr);
    mem_req_i = 1'b1;
    mem_adr_i = adr;
    while (!mem_ack_o) @(negedge clk_i);
    accepted++;   // Taken at the coming rising edge
    @(negedge clk_i);
    mem_req_i = 1'b0;
  endtask

  task automatic drain();
    while (parcels != accepted) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // Four sets with two tags each, so fills compete for ways
  function automatic logic [`ICACHE_XLEN-1:0] line_adr(input int n);
    return 32'h0004_0080 + 32'(n % 4) * 32'h10 + 32'(n / 4) * 32'h1000;
  endfunction

  task automatic mark_start();
    acc_base  = accepted;
    par_base  = parcels;
    perr_base = perrs;
    stb_base  = stb_cnt;
    chk_base  = i_dut.i_chk.fail_cnt;
  endtask

  // exp_stb below zero means any number of fills
  task automatic report_test(input string name, input int exp_stb, input int exp_err);
    int err0;
    err0 = errors;
    drain();
    if (parcels - par_base != accepted - acc_base) begin
      $display("ERR %s parcels: expected %0d, actual %0d", name,
               accepted - acc_base, parcels - par_base);
      errors++;
    end
    if (exp_stb >= 0 && stb_cnt - stb_base != exp_stb) begin
      $display("ERR %s bus requests: expected %0d, actual %0d", name,
               exp_stb, stb_cnt - stb_base);
      errors++;
    end
    if (stb_cnt != stb_base && stb_type != biu_pkg::INCR4) begin
      $display("ERR %s burst type: expected INCR4, actual %s", name, stb_type.name());
      errors++;
    end
    if (perrs - perr_base != exp_err) begin
      $display("ERR %s error parcels: expected %0d, actual %0d", name,
               exp_err, perrs - perr_base);
      errors++;
    end
    if (i_dut.i_chk.fail_cnt != chk_base) begin
      $display("%s: %0d assertions failed during the test", name,
               i_dut.i_chk.fail_cnt - chk_base);
      errors++;
    end
    ntests++;
    if (errors != err0) nfailed++;
    $display("test %-16s %s", name, (errors == err0) ? "ok" : "failed");
  endtask

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    seed          = 32'h3fdf9278;
    bus_seed      = seed;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    stb_q         = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    mark_start();
    repeat (4) @(negedge clk_i);   // Idle, outputs must stay quiet
    report_test("reset", 0, 0);

    mark_start();
    for (int w = 0; w < 4; w++) fetch(32'h0000_1000 + 4 * w);   // One fresh line
    report_test("line_fill", 1, 0);

    mark_start();
    for (int w = 3; w >= 0; w--) fetch(32'h0000_1000 + 4 * w);
    report_test("refetch", 0, 0);

    mark_start();
    fetch(32'h8000_2044);
    report_test("bus_error", 1, 1);

    mark_start();
    fetch(32'h8000_2044);   // Failed line was not stored
    report_test("bus_error_retry", 1, 1);

    mark_start();
    for (int n = 0; n < NumRand; n++) begin
      fetch(line_adr({$random(seed)} % 8) + 4 * ({$random(seed)} % 4));
      if ({$random(seed)} % 4 == 0) @(negedge clk_i);   // Gap now and then
    end
    report_test("random", -1, 0);

    $display("%0d tests run, %0d failed, %0d errors", ntests, nfailed, errors);
    if (errors == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- icache_top.f
+incdir+.
biu_pkg.sv
icache_pkg.sv
icache_setup.sv
icache_tag.sv
icache_memory.sv
icache_hit.sv
icache_biu_ctrl.sv
icache_top.sv
icache_chk.sv
icache_tb.sv

//--- icache_top.sv
// Two-way instruction cache, cacheable word fetches only
// Hits return two cycles after acceptance, requests are taken while mem_ack_o is high
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Core side
  input  logic                    mem_req_i,
  input  logic [`ICACHE_XLEN-1:0] mem_adr_i,
  output logic                    mem_ack_o,
  output logic                    parcel_valid_o,
  output logic [`ICACHE_XLEN-1:0] parcel_o,
  output logic [`ICACHE_XLEN-1:0] parcel_pc_o,
  output logic                    parcel_error_o,
  // Bus side
  output logic                    biu_stb_o,
  input  logic                    biu_stb_ack_i,
  output logic [`ICACHE_XLEN-1:0] biu_adri_o,
  output biu_pkg::biu_size_e      biu_size_o,
  output biu_pkg::biu_type_e      biu_type_o,
  output logic                    biu_we_o,
  input  logic [`ICACHE_XLEN-1:0] biu_q_i,
  input  logic                    biu_ack_i,
  input  logic                    biu_err_i
);

  logic                    stall;
  logic                    setup_req;
  logic                    tag_req;
  logic [`ICACHE_XLEN-1:0] setup_adr;
  logic [`ICACHE_XLEN-1:0] tag_adr;
  logic [`ICACHE_XLEN-1:0] fill_adr;
  icache_pkg::idx_t        rd_idx;
  icache_pkg::idx_t        wr_idx;
  icache_pkg::tag_t        wr_tag;
  logic                    hit;
  icache_pkg::line_t       cache_line;
  icache_pkg::line_t       biu_line;
  icache_pkg::biucmd_e     biucmd;
  logic                    biucmd_ack;
  logic                    fill_err;
  logic                    fill_we;
  logic                    filling;

  assign mem_ack_o = ~stall;

  // -------------------------------------------------------------------------
  // Fetch pipeline
  // -------------------------------------------------------------------------
  icache_setup i_setup (
    .clk_i, .rst_ni, .stall_i(stall), .req_i(mem_req_i), .adr_i(mem_adr_i),
    .setup_req_o(setup_req), .setup_adr_o(setup_adr), .rd_idx_o(rd_idx)
  );

  icache_tag i_tag (
    .clk_i, .rst_ni, .stall_i(stall), .req_i(setup_req), .adr_i(setup_adr),
    .tag_req_o(tag_req), .tag_adr_o(tag_adr)
  );

  icache_memory i_memory (
    .clk_i, .rst_ni, .rd_idx_i(rd_idx),
    .core_tag_i(tag_adr[`ICACHE_XLEN-1 -: `ICACHE_TAG_BITS]),
    .wr_idx_i(wr_idx), .wr_tag_i(wr_tag), .fill_we_i(fill_we), .filling_i(filling),
    .biu_line_i(biu_line), .hit_o(hit), .cache_line_o(cache_line)
  );

  icache_hit i_hit (
    .clk_i, .rst_ni, .tag_req_i(tag_req), .tag_adr_i(tag_adr), .hit_i(hit),
    .cache_line_i(cache_line), .biucmd_ack_i(biucmd_ack), .fill_err_i(fill_err),
    .biu_line_i(biu_line), .stall_o(stall), .filling_o(filling), .fill_we_o(fill_we),
    .biucmd_o(biucmd), .fill_adr_o(fill_adr), .wr_idx_o(wr_idx), .wr_tag_o(wr_tag),
    .parcel_valid_o, .parcel_o, .parcel_pc_o, .parcel_error_o
  );

  // -------------------------------------------------------------------------
  // Line fill
  // -------------------------------------------------------------------------
  icache_biu_ctrl i_biu_ctrl (
    .clk_i, .rst_ni, .biucmd_i(biucmd), .fill_adr_i(fill_adr),
    .biu_stb_ack_i, .biu_ack_i, .biu_err_i, .biu_q_i,
    .biucmd_ack_o(biucmd_ack), .fill_err_o(fill_err), .biu_line_o(biu_line),
    .biu_stb_o, .biu_adri_o, .biu_size_o, .biu_type_o, .biu_we_o
  );

endmodule
